// ==== source/mipsPkg.sv ====
package mipsPkg;

  // ====================
  // instruction encodings
  // ====================

  // major opcodes, bits 31:26 of the word
  typedef enum logic [5:0] {
    opRType = 6'h00,
    opJ     = 6'h02,
    opJal   = 6'h03,
    opBeq   = 6'h04,
    opAddi  = 6'h08,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcode_e;

  // r-type function field, bits 5:0
  // only meaningful when opcode is opRType
  typedef enum logic [5:0] {
    fnJr  = 6'h08,
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2a
  } funct_e;

  // ====================
  // alu operations
  // ====================

  // aluNone is zero so an all-zero control word is a nop
  typedef enum logic [2:0] {
    aluNone = 3'd0,
    aluAdd  = 3'd1,
    aluSub  = 3'd2,
    aluAnd  = 3'd3,
    aluOr   = 3'd4,
    aluSlt  = 3'd5
  } aluOp_e;

  // ====================
  // buses
  // ====================

  // decoded control, one per instruction
  typedef struct packed {
    logic   regWrite;  // write-back enable
    logic   memWrite;  // store strobe
    logic   memToReg;  // write back load data
    logic   aluSrc;    // second operand is the immediate
    logic   regDst;    // destination from rd, else rt
    logic   branch;    // beq
    logic   jump;      // j and jal
    logic   link;      // jal, writes pc + 4 to r31
    logic   jumpReg;   // jr
    aluOp_e aluOp;
  } ctrl_t;

  // register write bus, committed at the rising edge
  typedef struct packed {
    logic        en;
    logic [4:0]  addr;
    logic [31:0] data;
  } wbInfo_t;

  // data memory request
  // addr is a byte address
  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } dmemReq_t;

endpackage

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu import mipsPkg::*; (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  aluOp_e      op,
  output logic [31:0] result,
  output logic        zero
);

  // signed compare for slt
  logic lessThan;

  assign lessThan = $signed(a) < $signed(b);

  // ====================
  // operation select
  // ====================

  always_comb begin
    case (op)
      aluAdd:  result = a + b;
      aluSub:  result = a - b;
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      // one in bit 0 when a < b
      aluSlt:  result = {31'd0, lessThan};
      // aluNone and anything else
      default: result = '0;
    endcase
  end

  // flag for any op, beq only looks at it after aluSub
  assign zero = (result == '0);

endmodule

// ==== source/mipsDecoder.sv ====
`timescale 1ns/1ps

module mipsDecoder import mipsPkg::*; (
  input  logic [31:0] instr,
  output ctrl_t       ctrl
);

  // instruction fields used for decode
  opcode_e opcode;
  funct_e  funct;

  assign opcode = opcode_e'(instr[31:26]);
  assign funct  = funct_e'(instr[5:0]);

  // ====================
  // main and alu control
  // ====================

  always_comb begin
    // default is a nop
    ctrl       = '0;
    ctrl.aluOp = aluNone;

    case (opcode)
      opRType: begin
        // funct picks the alu operation
        case (funct)
          fnAdd: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            ctrl.aluOp    = aluAdd;
          end
          fnSub: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            ctrl.aluOp    = aluSub;
          end
          fnAnd: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            ctrl.aluOp    = aluAnd;
          end
          fnOr: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            ctrl.aluOp    = aluOr;
          end
          fnSlt: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            ctrl.aluOp    = aluSlt;
          end
          // jump to rs, nothing written
          fnJr:    ctrl.jumpReg = 1'b1;
          default: ctrl = '0;
        endcase
      end
      opAddi: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opLw: begin
        // address = rs + imm, load data to rt
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opSw: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opBeq: begin
        // equal when rs - rt is zero
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;
      end
      opJ:   ctrl.jump = 1'b1;
      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/1ps

module registerFile import mipsPkg::*; #(
  parameter int RegCount = 32
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rsAddr,
  input  logic [4:0]  rtAddr,
  input  wbInfo_t     wb,
  output logic [31:0] rsData,
  output logic [31:0] rtData
);

  // index width, upper address bits dropped for small files
  localparam int AddrBits = $clog2(RegCount);

  logic [31:0]         regs [RegCount];
  logic [AddrBits-1:0] rsIdx;
  logic [AddrBits-1:0] rtIdx;
  logic [AddrBits-1:0] wbIdx;

  assign rsIdx = rsAddr[AddrBits-1:0];
  assign rtIdx = rtAddr[AddrBits-1:0];
  assign wbIdx = wb.addr[AddrBits-1:0];

  // ====================
  // write port
  // ====================

  // register 0 is never written, so it stays at its cleared value
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < RegCount; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && (wbIdx != '0)) begin
      regs[wbIdx] <= wb.data;
    end
  end

  // ====================
  // read ports
  // ====================

  // combinational, no bypass
  // new value shows up the cycle after the write
  assign rsData = regs[rsIdx];
  assign rtData = regs[rtIdx];

endmodule

// ==== source/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit import mipsPkg::*; #(
  parameter logic [31:0] ResetPc = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        rst,
  input  ctrl_t       ctrl,
  input  logic [31:0] instr,
  input  logic [31:0] rsData,
  input  logic [31:0] rtData,
  input  logic [31:0] memReadData,
  output logic [31:0] pc,
  output wbInfo_t     wb,
  output dmemReq_t    dmem
);

  // link register for jal
  localparam logic [4:0] LinkReg = 5'd31;

  // instruction fields
  logic [4:0]  rtField;
  logic [4:0]  rdField;
  logic [15:0] immField;
  logic [25:0] targetField;

  // datapath
  logic [31:0] immExt;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic        aluZero;
  logic [31:0] pcPlus4;
  logic [31:0] branchTarget;
  logic [31:0] jumpTarget;
  logic [31:0] nextPc;

  assign rtField     = instr[20:16];
  assign rdField     = instr[15:11];
  assign immField    = instr[15:0];
  assign targetField = instr[25:0];

  // ====================
  // operands and alu
  // ====================

  // sign extend the immediate
  assign immExt = {{16{immField[15]}}, immField};
  assign aluB   = ctrl.aluSrc ? immExt : rtData;

  alu i_alu (
    .a      (rsData),
    .b      (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  // store request, address straight from the alu
  assign dmem.write = ctrl.memWrite;
  assign dmem.addr  = aluResult;
  assign dmem.wdata = rtData;

  // ====================
  // write-back
  // ====================

  assign wb.en = ctrl.regWrite;

  // destination, jal wins over regDst
  assign wb.addr = ctrl.link   ? LinkReg :
                   ctrl.regDst ? rdField : rtField;

  // jal links pc + 4, no delay slot
  assign wb.data = ctrl.link     ? pcPlus4     :
                   ctrl.memToReg ? memReadData : aluResult;

  // ====================
  // next pc
  // ====================

  assign pcPlus4      = pc + 32'd4;
  // word offset relative to pc + 4
  assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
  // region bits from pc + 4
  assign jumpTarget   = {pcPlus4[31:28], targetField, 2'b00};

  // priority jr, j/jal, taken beq, sequential
  always_comb begin
    if (ctrl.jumpReg) begin
      nextPc = rsData;
    end else if (ctrl.jump) begin
      nextPc = jumpTarget;
    end else if (ctrl.branch && aluZero) begin
      nextPc = branchTarget;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // one instruction per edge
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= ResetPc;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

// ==== source/mipsCore.sv ====
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; #(
  parameter logic [31:0] ResetPc  = 32'h0000_0000,
  parameter int          RegCount = 32
) (
  input  logic        clk,
  input  logic        rst,
  // instruction memory, asynchronous read
  output logic [31:0] instrAddr,
  input  logic [31:0] instr,
  // data memory, asynchronous read
  output dmemReq_t    dmem,
  input  logic [31:0] memReadData,
  // register write bus
  output wbInfo_t     wb
);

  // ====================
  // internal wires
  // ====================

  ctrl_t       ctrl;
  logic [31:0] rsData;
  logic [31:0] rtData;

  // decode and register read run side by side on instr
  mipsDecoder i_decoder (
    .instr (instr),
    .ctrl  (ctrl)
  );

  // rs and rt fields straight from the word
  registerFile #(
    .RegCount (RegCount)
  ) i_regFile (
    .clk    (clk),
    .rst    (rst),
    .rsAddr (instr[25:21]),
    .rtAddr (instr[20:16]),
    .wb     (wb),
    .rsData (rsData),
    .rtData (rtData)
  );

  // combines control and operands
  // pc leaves as the fetch address
  executeUnit #(
    .ResetPc (ResetPc)
  ) i_execute (
    .clk         (clk),
    .rst         (rst),
    .ctrl        (ctrl),
    .instr       (instr),
    .rsData      (rsData),
    .rtData      (rtData),
    .memReadData (memReadData),
    .pc          (instrAddr),
    .wb          (wb),
    .dmem        (dmem)
  );

endmodule

// ==== testbench/mipsCore_checker.sv ====
`timescale 1ns/1ps

module mipsCore_checker import mipsPkg::*; #(
  parameter logic [31:0] ResetPc = 32'h0000_0000
) (
  input logic        clk,
  input logic        rst,
  input logic [31:0] instrAddr,
  input wbInfo_t     wb,
  input dmemReq_t    dmem
);

  // fetch address always on a word boundary
  wordAligned: assert property (@(posedge clk) disable iff (!rst)
    instrAddr[1:0] == 2'b00)
    else $error("instrAddr %h not word aligned", instrAddr);

  // no instruction both writes a register and stores
  noWbWithStore: assert property (@(posedge clk) disable iff (!rst)
    !(wb.en && dmem.write))
    else $error("wb.en and dmem.write set together");

  // pc parked at its reset value
  pcInReset: assert property (@(posedge clk)
    !rst |-> instrAddr == ResetPc)
    else $error("instrAddr %h differs from reset pc during reset", instrAddr);

endmodule

bind mipsCore mipsCore_checker #(
  .ResetPc (ResetPc)
) i_checker (
  .clk       (clk),
  .rst       (rst),
  .instrAddr (instrAddr),
  .wb        (wb),
  .dmem      (dmem)
);

// ==== testbench/mipsTb.sv ====
`timescale 1ns/1ps

module mipsTb import mipsPkg::*; ();

  localparam logic [31:0] ResetPc   = 32'h0000_0000;
  localparam int          ProgLen   = 64;
  localparam int          LastIdx   = ProgLen - 1;
  localparam logic [31:0] FinalPc   = 32'(LastIdx * 4);
  localparam int          DataWords = 256;
  localparam logic [4:0]  BaseReg   = 5'd29;
  localparam logic [4:0]  JrReg     = 5'd30;
  localparam logic [15:0] BaseAddr  = 16'h0200;
  localparam int          MaxSteps  = 200;

  logic        clk;
  logic        rst;
  logic [31:0] instrAddr;
  logic [31:0] instr;
  logic [31:0] memReadData;
  dmemReq_t    dmem;
  wbInfo_t     wb;
  logic        finished = 1'b0;

  logic [31:0] progMem [ProgLen];
  logic [31:0] dataMem [DataWords];

  // words that some jump or branch may land on
  bit          landed  [ProgLen];

  // reference state kept apart from the memory models
  logic [31:0] refRegs [32];
  logic [31:0] refMem  [DataWords];
  logic [31:0] refPc;

  mipsCore #(
    .ResetPc  (ResetPc),
    .RegCount (32)
  ) i_dut (
    .clk         (clk),
    .rst         (rst),
    .instrAddr   (instrAddr),
    .instr       (instr),
    .dmem        (dmem),
    .memReadData (memReadData),
    .wb          (wb)
  );

  // ====================
  // memory models
  // ====================

  always #2 clk = ~clk;

  assign instr       = progMem[instrAddr[7:2]];
  assign memReadData = dataMem[dmem.addr[9:2]];

  // odd multiplier gives every word index its own value
  function automatic logic [31:0] fillWord(input int k);
    return (32'(k) * 32'h9e37_79b9) ^ 32'hc0de_0000;
  endfunction

  // reload during reset and store once running
  always @(posedge clk) begin
    if (!rst) begin
      for (int k = 0; k < DataWords; k++) begin
        dataMem[k] <= fillWord(k);
      end
    end else if (dmem.write) begin
      dataMem[dmem.addr[9:2]] <= dmem.wdata;
    end
  end

  // ====================
  // program generator
  // ====================

  function automatic logic [31:0] rType(input logic [4:0] rs, rt, rd, input funct_e fn);
    return {opRType, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] iType(input opcode_e op, input logic [4:0] rs, rt,
                                        input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jType(input opcode_e op, input int target);
    return {op, 26'(target)};
  endfunction

  // destinations avoid base, jr scratch and link registers
  function automatic logic [4:0] pickDest();
    return 5'($urandom_range(0, 28));
  endfunction

  function automatic logic [4:0] pickSrc();
    return 5'($urandom_range(0, 31));
  endfunction

  // forward only so the program always reaches its end
  function automatic int pickTarget(input int from);
    int t;
    t = from + 1 + int'($urandom_range(0, 3));
    if (t > LastIdx) t = LastIdx;
    landed[t] = 1'b1;
    return t;
  endfunction

  task automatic buildProgram();
    int         i;
    int         kind;
    logic [4:0] rs;
    logic [4:0] rt;
    progMem[0] = iType(opAddi, 5'd0, BaseReg, BaseAddr);
    i = 1;
    while (i < LastIdx) begin
      kind = int'($urandom_range(0, 12));
      rs   = pickSrc();
      // equal operands half the time so some beq are taken
      rt   = ($urandom_range(0, 1) == 1) ? rs : pickSrc();
      case (kind)
        0:  progMem[i] = rType(rs, rt, pickDest(), fnAdd);
        1:  progMem[i] = rType(rs, rt, pickDest(), fnSub);
        2:  progMem[i] = rType(rs, rt, pickDest(), fnAnd);
        3:  progMem[i] = rType(rs, rt, pickDest(), fnOr);
        4:  progMem[i] = rType(rs, rt, pickDest(), fnSlt);
        5:  progMem[i] = iType(opAddi, rs, pickDest(), 16'($urandom));
        6:  progMem[i] = iType(opLw, BaseReg, pickDest(), 16'($urandom_range(0, 15) * 4));
        7:  progMem[i] = iType(opSw, BaseReg, rt, 16'($urandom_range(0, 15) * 4));
        8:  progMem[i] = iType(opBeq, rs, rt, 16'(pickTarget(i) - i - 1));
        9:  progMem[i] = jType(opJ, pickTarget(i));
        10: progMem[i] = jType(opJal, pickTarget(i));
        11: begin
          // jr needs a valid address loaded just before it
          // so no earlier jump may land on the jr itself
          if (i + 1 < LastIdx && !landed[i + 1]) begin
            progMem[i] = iType(opAddi, 5'd0, JrReg, 16'(pickTarget(i + 1) * 4));
            i++;
            progMem[i] = rType(JrReg, 5'd0, 5'd0, fnJr);
          end else begin
            progMem[i] = rType(rs, rt, 5'd0, fnAdd);
          end
        end
        // unknown opcode or unknown funct
        default: progMem[i] = ($urandom_range(0, 1) == 1) ? {6'h3f, 26'($urandom)} :
                                                            {6'h00, 20'($urandom), 6'h3f};
      endcase
      i++;
    end
    // closing self-jump
    progMem[LastIdx] = jType(opJ, LastIdx);
  endtask

  // ====================
  // reference model
  // ====================

  function automatic void stepRef(output wbInfo_t expWb, output dmemReq_t expMem);
    logic [31:0] word;
    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [31:0] imm;
    logic [31:0] pcNext;
    logic [4:0]  rt;
    logic [4:0]  rd;
    word   = progMem[refPc[7:2]];
    rsVal  = refRegs[word[25:21]];
    rtVal  = refRegs[word[20:16]];
    rt     = word[20:16];
    rd     = word[15:11];
    imm    = {{16{word[15]}}, word[15:0]};
    expWb  = '0;
    expMem = '0;
    pcNext = refPc + 32'd4;
    case (opcode_e'(word[31:26]))
      opRType: begin
        case (funct_e'(word[5:0]))
          fnAdd: expWb = '{en: 1'b1, addr: rd, data: rsVal + rtVal};
          fnSub: expWb = '{en: 1'b1, addr: rd, data: rsVal - rtVal};
          fnAnd: expWb = '{en: 1'b1, addr: rd, data: rsVal & rtVal};
          fnOr:  expWb = '{en: 1'b1, addr: rd, data: rsVal | rtVal};
          fnSlt: expWb = '{en: 1'b1, addr: rd, data: {31'd0, $signed(rsVal) < $signed(rtVal)}};
          fnJr:  pcNext = rsVal;
          default: ;
        endcase
      end
      opAddi: expWb = '{en: 1'b1, addr: rt, data: rsVal + imm};
      opLw:   expWb = '{en: 1'b1, addr: rt, data: refMem[(rsVal + imm) >> 2 & 32'hff]};
      opSw: begin
        expMem = '{write: 1'b1, addr: rsVal + imm, wdata: rtVal};
        refMem[expMem.addr[9:2]] = rtVal;
      end
      opBeq: begin
        if (rsVal == rtVal) pcNext = refPc + 32'd4 + {imm[29:0], 2'b00};
      end
      opJ:   pcNext = {pcNext[31:28], word[25:0], 2'b00};
      opJal: begin
        // link is pc + 4 with no delay slot
        expWb  = '{en: 1'b1, addr: 5'd31, data: refPc + 32'd4};
        pcNext = {pcNext[31:28], word[25:0], 2'b00};
      end
      default: ;
    endcase
    if (expWb.en && expWb.addr != 5'd0) refRegs[expWb.addr] = expWb.data;
    refPc = pcNext;
  endfunction

  // ====================
  // checks
  // ====================

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkPc(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL instrAddr got %h expected %h", got, exp);
      abortRun("program counter mismatch");
    end
  endtask

  task automatic checkWriteBack(input wbInfo_t got, input wbInfo_t exp);
    if (got.en !== exp.en) begin
      $display("FAIL wb.en got %h expected %h", got.en, exp.en);
      abortRun("write-back enable mismatch");
    end
    // addr and data only matter when enabled
    if (exp.en && (got.addr !== exp.addr || got.data !== exp.data)) begin
      $display("FAIL wb got addr %h data %h expected addr %h data %h",
               got.addr, got.data, exp.addr, exp.data);
      abortRun("write-back value mismatch");
    end
  endtask

  task automatic checkStore(input dmemReq_t got, input dmemReq_t exp);
    if (got.write !== exp.write) begin
      $display("FAIL dmem.write got %h expected %h", got.write, exp.write);
      abortRun("store strobe mismatch");
    end
    if (exp.write && (got.addr !== exp.addr || got.wdata !== exp.wdata)) begin
      $display("FAIL dmem got addr %h wdata %h expected addr %h wdata %h",
               got.addr, got.wdata, exp.addr, exp.wdata);
      abortRun("store value mismatch");
    end
  endtask

  // compare at the falling edge once per instruction
  initial begin : compare
    wbInfo_t  expWb;
    dmemReq_t expMem;
    int       steps;
    logic     atEnd;
    for (int k = 0; k < 32; k++) refRegs[k] = '0;
    for (int k = 0; k < DataWords; k++) refMem[k] = fillWord(k);
    refPc = ResetPc;
    steps = 0;
    atEnd = 1'b0;
    while (rst !== 1'b1) begin
      @(negedge clk);
      steps++;
      if (steps > 20) abortRun("reset was never released");
    end
    steps = 0;
    while (!atEnd) begin
      checkPc(instrAddr, refPc);
      atEnd = (refPc == FinalPc);
      stepRef(expWb, expMem);
      checkWriteBack(wb, expWb);
      checkStore(dmem, expMem);
      if (!atEnd) begin
        @(negedge clk);
        steps++;
        if (steps > MaxSteps) abortRun("final pc not reached in time");
      end
    end
    finished = 1'b1;
  end

  // ====================
  // run control
  // ====================

  initial begin : run
    int waitCycles;
    clk = 1'b0;
    rst <= 1'b0;
    void'($urandom(32'had1e));
    buildProgram();
    repeat (8) @(posedge clk);
    rst <= 1'b1;
    waitCycles = 0;
    while (!finished) begin
      @(posedge clk);
      waitCycles++;
      if (waitCycles > MaxSteps + 30) abortRun("compare process did not finish");
    end
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== build.f ====
source/mipsPkg.sv
source/alu.sv
source/mipsDecoder.sv
source/registerFile.sv
source/executeUnit.sv
source/mipsCore.sv
testbench/mipsCore_checker.sv
testbench/mipsTb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := mipsTb
FILELIST  := build.f
LOG       := sim.log
FAIL_MSG  := TEST FAILED
PASS_MSG  := TEST OK
BIN       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
